//--- src/vmul_pkg.sv
//**********************************************************
// Vector multiply lane package
// Lane word, element width and configuration types, plus the
// helpers that size and index the vedic sub-product arrays
//**********************************************************

package vmul_pkg;

    localparam int LANE_WIDTH = 32;

    typedef logic [LANE_WIDTH-1:0] word_t;

    // 0 selects the low half of the product, 1 the high half
    typedef logic sel_t;

    // Code 2'b11 is not used
    typedef enum logic [1:0] {
        SEW8  = 2'b00,
        SEW16 = 2'b01,
        SEW32 = 2'b10
    } sew_e;

    typedef enum logic [1:0] {
        VEDIC_LA_LB = 2'b00,
        VEDIC_LA_HB = 2'b01,
        VEDIC_HA_LB = 2'b10,
        VEDIC_HA_HB = 2'b11
    } vedic_mul_idx_t;

    typedef struct packed {
        sew_e sew;
        sel_t high;
    } vmul_cfg_t;

    typedef struct packed {
        word_t     a;
        word_t     b;
        vmul_cfg_t cfg;
    } vmul_op_t;

    // Position of a diagonal product formed at prod_level inside the
    // prev_result array of an instance at level, elements low first
    function automatic int f_vedic_mul_prev_idx(int level, int min_level,
                                                int prod_level, int pos);
        int idx;
        idx = pos;
        for (int j = min_level + 1; j < prod_level; j++) begin
            idx += 2 ** (level - j + 1);
        end
        return idx;
    endfunction

    // Off-diagonal instances export nothing; the top is built as LA_LB
    function automatic int f_vedic_mul_get_prev_results(int level, int min_level,
                                                        vedic_mul_idx_t idx);
        if (level <= min_level) begin
            return 0;
        end
        if (idx == VEDIC_LA_HB || idx == VEDIC_HA_LB) begin
            return 0;
        end
        return f_vedic_mul_prev_idx(level, min_level, level + 1, 0);
    endfunction

endpackage

//--- src/adder_nbit.sv
//**********************************************************
// N-bit adder with carry in and carry out
// Built as a full-adder ripple chain or as a plain sum
//**********************************************************

module adder_nbit #(
    parameter int WIDTH        = 8,
    parameter bit RIPPLE_CARRY = 1'b1
) (
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    input  logic             cin,
    output logic [WIDTH-1:0] s,
    output logic             cout
);

    generate
        if (RIPPLE_CARRY) begin : gen_ripple
            logic [WIDTH:0] carry;

            assign carry[0] = cin;

            for (genvar i = 0; i < WIDTH; i++) begin : gen_fa
                assign s[i]       = a[i] ^ b[i] ^ carry[i];
                assign carry[i+1] = (a[i] & b[i]) | (carry[i] & (a[i] ^ b[i]));
            end

            assign cout = carry[WIDTH];
        end else begin : gen_behav
            assign {cout, s} = {1'b0, a} + {1'b0, b} + {{WIDTH{1'b0}}, cin};
        end
    endgenerate

endmodule

//--- src/vedic_mul_unsigned.sv
//**********************************************************
// Recursive unsigned vedic multiplier
// Splits operands in halves down to a 2x2 core and exports
// the diagonal sub-products for packed narrow elements
//**********************************************************

module vedic_mul_unsigned #(
    parameter int                       WIDTH         = 32,
    parameter vmul_pkg::vedic_mul_idx_t MUL_IDX       = vmul_pkg::VEDIC_LA_LB,
    parameter int                       MIN_MUL_LEVEL = 3,
    localparam int RESULT_WIDTH     = 2 * WIDTH,
    localparam int MUL_LEVEL        = $clog2(WIDTH),
    localparam int NUM_PREV_RESULTS =
        vmul_pkg::f_vedic_mul_get_prev_results(MUL_LEVEL, MIN_MUL_LEVEL, MUL_IDX),
    localparam int PREV_DEPTH       = (NUM_PREV_RESULTS > 0) ? NUM_PREV_RESULTS : 1
) (
    input  logic [WIDTH-1:0]        a,
    input  logic [WIDTH-1:0]        b,
    output logic [RESULT_WIDTH-1:0] z,
    output logic [WIDTH-1:0]        prev_result [PREV_DEPTH-1:0]
);

    localparam int HALF_WIDTH = WIDTH / 2;

    generate
        if (WIDTH > 2) begin : gen_recursive
            localparam int CHILD_NUM = vmul_pkg::f_vedic_mul_get_prev_results(
                MUL_LEVEL - 1, MIN_MUL_LEVEL, vmul_pkg::VEDIC_LA_LB);
            localparam int CHILD_DEPTH = (CHILD_NUM > 0) ? CHILD_NUM : 1;

            logic [WIDTH-1:0]      mul_ll;
            logic [WIDTH-1:0]      mul_lh;
            logic [WIDTH-1:0]      mul_hl;
            logic [WIDTH-1:0]      mul_hh;
            logic [HALF_WIDTH-1:0] prev_ll [CHILD_DEPTH-1:0];
            logic [HALF_WIDTH-1:0] prev_hh [CHILD_DEPTH-1:0];
            logic [WIDTH-1:0]      mid_sum;
            logic [WIDTH-1:0]      low_sum;
            logic [WIDTH-1:0]      high_sum;
            logic                  mid_cout;
            logic                  low_cout;
            logic                  carry_fold;

            vedic_mul_unsigned #(
                .WIDTH         (HALF_WIDTH),
                .MUL_IDX       (vmul_pkg::VEDIC_LA_LB),
                .MIN_MUL_LEVEL (MIN_MUL_LEVEL)
            ) mul_la_lb (
                .a           (a[HALF_WIDTH-1:0]),
                .b           (b[HALF_WIDTH-1:0]),
                .z           (mul_ll),
                .prev_result (prev_ll)
            );

            vedic_mul_unsigned #(
                .WIDTH         (HALF_WIDTH),
                .MUL_IDX       (vmul_pkg::VEDIC_LA_HB),
                .MIN_MUL_LEVEL (MIN_MUL_LEVEL)
            ) mul_la_hb (
                .a           (a[HALF_WIDTH-1:0]),
                .b           (b[WIDTH-1:HALF_WIDTH]),
                .z           (mul_lh),
                .prev_result ()
            );

            vedic_mul_unsigned #(
                .WIDTH         (HALF_WIDTH),
                .MUL_IDX       (vmul_pkg::VEDIC_HA_LB),
                .MIN_MUL_LEVEL (MIN_MUL_LEVEL)
            ) mul_ha_lb (
                .a           (a[WIDTH-1:HALF_WIDTH]),
                .b           (b[HALF_WIDTH-1:0]),
                .z           (mul_hl),
                .prev_result ()
            );

            vedic_mul_unsigned #(
                .WIDTH         (HALF_WIDTH),
                .MUL_IDX       (vmul_pkg::VEDIC_HA_HB),
                .MIN_MUL_LEVEL (MIN_MUL_LEVEL)
            ) mul_ha_hb (
                .a           (a[WIDTH-1:HALF_WIDTH]),
                .b           (b[WIDTH-1:HALF_WIDTH]),
                .z           (mul_hh),
                .prev_result (prev_hh)
            );

            // Cross products
            adder_nbit #(.WIDTH(WIDTH), .RIPPLE_CARRY(1'b1)) mid_adder (
                .a    (mul_lh),
                .b    (mul_hl),
                .cin  (1'b0),
                .s    (mid_sum),
                .cout (mid_cout)
            );

            adder_nbit #(.WIDTH(WIDTH), .RIPPLE_CARRY(1'b1)) low_adder (
                .a    ({{HALF_WIDTH{1'b0}}, mul_ll[WIDTH-1:HALF_WIDTH]}),
                .b    (mid_sum),
                .cin  (1'b0),
                .s    (low_sum),
                .cout (low_cout)
            );

            // Both carries share one weight and never rise together
            assign carry_fold = low_cout | mid_cout;

            adder_nbit #(.WIDTH(WIDTH), .RIPPLE_CARRY(1'b1)) high_adder (
                .a    ({{(HALF_WIDTH-1){1'b0}}, carry_fold, low_sum[WIDTH-1:HALF_WIDTH]}),
                .b    (mul_hh),
                .cin  (1'b0),
                .s    (high_sum),
                .cout ()
            );

            assign z = {high_sum, low_sum[HALF_WIDTH-1:0], mul_ll[HALF_WIDTH-1:0]};

            if (NUM_PREV_RESULTS > 0) begin : gen_export
                // Lower levels first, LA_LB child before HA_HB child
                for (genvar k = MIN_MUL_LEVEL + 1; k < MUL_LEVEL; k++) begin : gen_lvl
                    localparam int N = 2 ** (MUL_LEVEL - k);
                    for (genvar p = 0; p < N; p++) begin : gen_pos
                        localparam int SRC =
                            vmul_pkg::f_vedic_mul_prev_idx(MUL_LEVEL - 1, MIN_MUL_LEVEL, k, p);
                        localparam int DST_L =
                            vmul_pkg::f_vedic_mul_prev_idx(MUL_LEVEL, MIN_MUL_LEVEL, k, p);
                        localparam int DST_H =
                            vmul_pkg::f_vedic_mul_prev_idx(MUL_LEVEL, MIN_MUL_LEVEL, k, N + p);
                        assign prev_result[DST_L] = {{HALF_WIDTH{1'b0}}, prev_ll[SRC]};
                        assign prev_result[DST_H] = {{HALF_WIDTH{1'b0}}, prev_hh[SRC]};
                    end
                end
                assign prev_result[NUM_PREV_RESULTS-2] = mul_ll;
                assign prev_result[NUM_PREV_RESULTS-1] = mul_hh;
            end else begin : gen_no_export
                assign prev_result[0] = '0;
            end
        end else begin : gen_base
            logic carry1;

            // 2x2 core from half adders
            assign z[0]   = a[0] & b[0];
            assign z[1]   = (a[1] & b[0]) ^ (a[0] & b[1]);
            assign carry1 = (a[1] & b[0]) & (a[0] & b[1]);
            assign z[2]   = (a[1] & b[1]) ^ carry1;
            assign z[3]   = (a[1] & b[1]) & carry1;

            if (NUM_PREV_RESULTS > 0) begin : gen_export
                assign prev_result[0] = {1'b0, a[0] & b[0]};
                assign prev_result[1] = {1'b0, a[1] & b[1]};
            end else begin : gen_no_export
                assign prev_result[0] = '0;
            end
        end
    endgenerate

    initial begin
        if (WIDTH < 2 || (WIDTH & (WIDTH - 1)) != 0) begin
            $fatal(1, "vedic_mul_unsigned: WIDTH %0d is not a power of two", WIDTH);
        end
    end

endmodule

//--- src/vmul_cfg_regs.sv
//**********************************************************
// Lane configuration registers
// Holds element width and high-half select for new operations
//**********************************************************

module vmul_cfg_regs (
    input  logic                clk,
    input  logic                rst,
    input  logic                cfg_we,
    input  vmul_pkg::vmul_cfg_t cfg_in,
    output vmul_pkg::vmul_cfg_t cfg
);

    logic sew_ok;

    // Only the three defined element widths are accepted
    always_comb begin
        case (cfg_in.sew)
            vmul_pkg::SEW8,
            vmul_pkg::SEW16,
            vmul_pkg::SEW32: begin
                sew_ok = 1'b1;
            end
            default: begin
                sew_ok = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg <= '{sew: vmul_pkg::SEW32, high: 1'b0};
        end else if (cfg_we && sew_ok) begin
            cfg <= cfg_in;
        end
    end

endmodule

//--- src/vmul_lane.sv
//**********************************************************
// Vector multiply lane
// Two-stage unsigned multiply of packed 8, 16 or 32-bit elements
//**********************************************************

module vmul_lane #(
    parameter int MIN_MUL_LEVEL = 3
) (
    input  logic                clk,
    input  logic                rst,
    input  vmul_pkg::vmul_cfg_t cfg,
    input  logic                in_valid,
    input  vmul_pkg::word_t     a,
    input  vmul_pkg::word_t     b,
    output logic                out_valid,
    output vmul_pkg::word_t     result
);

    localparam int W         = vmul_pkg::LANE_WIDTH;
    localparam int MUL_LEVEL = $clog2(W);
    localparam int PREV_NUM  =
        vmul_pkg::f_vedic_mul_get_prev_results(MUL_LEVEL, MIN_MUL_LEVEL, vmul_pkg::VEDIC_LA_LB);

    vmul_pkg::vmul_op_t op_q;
    logic               op_valid_q;
    logic [2*W-1:0]     prod_full;
    vmul_pkg::word_t    prev [PREV_NUM-1:0];
    vmul_pkg::word_t    prod16 [2];
    logic [15:0]        prod8 [4];
    vmul_pkg::word_t    res_d;

    // Stage 1
    always_ff @(posedge clk) begin
        if (rst) begin
            op_valid_q <= 1'b0;
        end else begin
            op_valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            op_q <= '{a: a, b: b, cfg: cfg};
        end
    end

    vedic_mul_unsigned #(
        .WIDTH         (W),
        .MUL_IDX       (vmul_pkg::VEDIC_LA_LB),
        .MIN_MUL_LEVEL (MIN_MUL_LEVEL)
    ) mul_inst (
        .a           (op_q.a),
        .b           (op_q.b),
        .z           (prod_full),
        .prev_result (prev)
    );

    // 16x16 products come from the top diagonal, 8x8 from one level down
    for (genvar e = 0; e < 2; e++) begin : gen_p16
        assign prod16[e] = prev[vmul_pkg::f_vedic_mul_prev_idx(MUL_LEVEL, MIN_MUL_LEVEL, 5, e)];
    end
    for (genvar e = 0; e < 4; e++) begin : gen_p8
        assign prod8[e] = prev[vmul_pkg::f_vedic_mul_prev_idx(MUL_LEVEL, MIN_MUL_LEVEL, 4, e)][15:0];
    end

    always_comb begin
        res_d = prod_full[W-1:0];
        case (op_q.cfg.sew)
            vmul_pkg::SEW32: begin
                res_d = op_q.cfg.high ? prod_full[2*W-1:W] : prod_full[W-1:0];
            end
            vmul_pkg::SEW16: begin
                for (int e = 0; e < 2; e++) begin
                    res_d[e*16 +: 16] = op_q.cfg.high ? prod16[e][31:16] : prod16[e][15:0];
                end
            end
            vmul_pkg::SEW8: begin
                for (int e = 0; e < 4; e++) begin
                    res_d[e*8 +: 8] = op_q.cfg.high ? prod8[e][15:8] : prod8[e][7:0];
                end
            end
            default: begin
            end
        endcase
    end

    // Result register holds between operations
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= op_valid_q;
        end
    end

    always_ff @(posedge clk) begin
        if (op_valid_q) begin
            result <= res_d;
        end
    end

endmodule

//--- src/vmul_top.sv
//**********************************************************
// Vector multiply lane top level
// Configuration registers feeding one multiply lane
//**********************************************************

module vmul_top #(
    parameter int MIN_MUL_LEVEL = 3
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                cfg_we,
    input  vmul_pkg::vmul_cfg_t cfg_in,
    input  logic                in_valid,
    input  vmul_pkg::word_t     a,
    input  vmul_pkg::word_t     b,
    output logic                out_valid,
    output vmul_pkg::word_t     result
);

    vmul_pkg::vmul_cfg_t cfg;

    vmul_cfg_regs cfg_regs_inst (
        .clk    (clk),
        .rst    (rst),
        .cfg_we (cfg_we),
        .cfg_in (cfg_in),
        .cfg    (cfg)
    );

    vmul_lane #(
        .MIN_MUL_LEVEL (MIN_MUL_LEVEL)
    ) lane_inst (
        .clk       (clk),
        .rst       (rst),
        .cfg       (cfg),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .out_valid (out_valid),
        .result    (result)
    );

endmodule

//--- verif/vmul_chk.sv
//**********************************************************
// Lane timing assertions
// Reset, two-cycle latency and legal SEW in the lane config
//**********************************************************

module vmul_chk (
    input logic                clk,
    input logic                rst,
    input logic                in_valid,
    input logic                out_valid,
    input vmul_pkg::vmul_cfg_t cfg
);
    timeunit 1ns;
    timeprecision 1ps;

    reset_clears_valid: assert property (@(posedge clk) rst |=> !out_valid)
        else $error("out_valid high after a reset cycle");

    // Issue sampled at one edge answers two edges later
    two_cycle_latency: assert property (@(posedge clk) disable iff (rst)
        out_valid == $past(in_valid, 2))
        else $error("out_valid does not follow in_valid by two cycles");

    sew_code_legal: assert property (@(posedge clk) disable iff (rst) cfg.sew != 2'b11)
        else $error("lane configuration holds the unused SEW code");

endmodule

//--- verif/vmul_monitor.sv
//**********************************************************
// Lane monitor
// Models the configuration and element products, checks results
//**********************************************************

module vmul_monitor (
    input  logic                clk,
    input  logic                rst,
    input  logic                cfg_we,
    input  vmul_pkg::vmul_cfg_t cfg_in,
    input  logic                in_valid,
    input  vmul_pkg::word_t     a,
    input  vmul_pkg::word_t     b,
    input  logic                out_valid,
    input  vmul_pkg::word_t     result,
    output int                  check_count,
    output int                  error_count,
    output int                  pending
);
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        vmul_pkg::vmul_op_t op;
        int unsigned        cycle;
    } pend_t;

    pend_t               pend_q[$];
    pend_t               issued;
    vmul_pkg::vmul_cfg_t model_cfg;
    int unsigned         cycle = 0;

    function automatic int elem_width(vmul_pkg::sew_e sew);
        case (sew)
            vmul_pkg::SEW8:  return 8;
            vmul_pkg::SEW16: return 16;
            default:         return 32;
        endcase
    endfunction

    // Low or high half of element e's double-width product
    function automatic logic [31:0] expected_elem(vmul_pkg::vmul_op_t op, int e);
        int          w;
        logic [63:0] mask;
        logic [63:0] prod;
        w    = elem_width(op.cfg.sew);
        mask = (64'd1 << w) - 64'd1;
        prod = ((64'(op.a) >> (e * w)) & mask) * ((64'(op.b) >> (e * w)) & mask);
        return 32'(op.cfg.high ? (prod >> w) & mask : prod & mask);
    endfunction

    task automatic check_result();
        pend_t       p;
        int          w;
        logic [31:0] got;
        logic [31:0] exp;
        if (pend_q.size() == 0) begin
            $display("ERROR at %0t: out_valid rose with no operation outstanding", $time);
            error_count++;
            return;
        end
        p = pend_q.pop_front();
        check_count++;
        if (cycle != p.cycle + 2) begin
            $display("ERROR at %0t: result came %0d cycles after issue instead of 2",
                     $time, cycle - p.cycle);
            error_count++;
        end
        w = elem_width(p.op.cfg.sew);
        for (int e = 0; e < 32 / w; e++) begin
            got = 32'((64'(result) >> (e * w)) & ((64'd1 << w) - 64'd1));
            exp = expected_elem(p.op, e);
            if (got !== exp) begin
                $display("FAIL %0t: element %0d SEW%0d high=%0b a=%h b=%h got %h expected %h",
                         $time, e, w, p.op.cfg.high, p.op.a, p.op.b, got, exp);
                error_count++;
            end
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            model_cfg = '{sew: vmul_pkg::SEW32, high: 1'b0};
            pend_q.delete();
        end else begin
            if (out_valid) begin
                check_result();
            end
            if (in_valid) begin
                issued = '{op: '{a: a, b: b, cfg: model_cfg}, cycle: cycle};
                pend_q.push_back(issued);
            end
            // A write counts from the next issue on and the unused code is ignored
            if (cfg_we && cfg_in.sew != 2'b11) begin
                model_cfg = cfg_in;
            end
        end
        pending = pend_q.size();
        cycle++;
    end

endmodule

//--- verif/vmul_tb.sv
//**********************************************************
// Vector multiply lane testbench
// Seeded random operations over element widths and halves
//**********************************************************

module vmul_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DRAIN_LIMIT = 40;

    logic                clk;
    logic                rst;
    logic                cfg_we;
    vmul_pkg::vmul_cfg_t cfg_in;
    logic                in_valid;
    vmul_pkg::word_t     a;
    vmul_pkg::word_t     b;
    logic                out_valid;
    vmul_pkg::word_t     result;
    int                  check_count;
    int                  error_count;
    int                  pending;
    int                  tests_failed = 0;
    int                  test_num = 0;
    int                  errors_before = 0;
    bit                  timed_out = 1'b0;

    always #20 clk = ~clk;

    vmul_top #(.MIN_MUL_LEVEL(3)) vmul_top_inst (.*);

    vmul_monitor monitor_inst (.*);

    bind vmul_lane vmul_chk chk_inst (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .out_valid (out_valid),
        .cfg       (cfg)
    );

    function automatic vmul_pkg::vmul_cfg_t make_cfg(vmul_pkg::sew_e sew, logic high);
        vmul_pkg::vmul_cfg_t c;
        c.sew  = sew;
        c.high = high;
        return c;
    endfunction

    function automatic vmul_pkg::vmul_cfg_t random_cfg();
        return make_cfg(vmul_pkg::sew_e'(2'($urandom % 3)), 1'($urandom));
    endfunction

    task automatic drive_cycle(input logic iv, input vmul_pkg::word_t av,
                               input vmul_pkg::word_t bv, input logic we,
                               input vmul_pkg::vmul_cfg_t c);
        @(posedge clk);
        in_valid <= iv;
        a        <= av;
        b        <= bv;
        cfg_we   <= we;
        cfg_in   <= c;
    endtask

    task automatic packed_test(input vmul_pkg::sew_e sew, input string name);
        for (int h = 0; h < 2; h++) begin
            drive_cycle(1'b0, '0, '0, 1'b1, make_cfg(sew, 1'(h)));
            drive_cycle(1'b1, '1, '1, 1'b0, '0);
            drive_cycle(1'b1, 32'h00FF_FFFF, 32'hFF01_FFFF, 1'b0, '0);
            repeat (10) drive_cycle(1'b1, $urandom, $urandom, 1'b0, '0);
        end
        end_test(name);
    endtask

    // Idle the inputs, then wait for every outstanding result
    task automatic end_test(input string name);
        int waited;
        drive_cycle(1'b0, '0, '0, 1'b0, '0);
        waited = 0;
        @(negedge clk);
        while (pending != 0 && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        test_num++;
        if (pending != 0) begin
            $display("Timeout: %0d results of test %0d never came out", pending, test_num);
            timed_out = 1'b1;
        end
        if (pending != 0 || error_count != errors_before) begin
            tests_failed++;
        end
        $display("Test %0d %s: %0d errors, %0d results checked so far",
                 test_num, name, error_count - errors_before, check_count);
        errors_before = error_count;
    endtask

    initial begin
        vmul_pkg::vmul_cfg_t bad;
        clk      = 1'b0;
        rst      = 1'b1;
        cfg_we   = 1'b0;
        cfg_in   = '0;
        in_valid = 1'b0;
        a        = '0;
        b        = '0;
        bad      = 3'b110;
        void'($urandom(53));
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        repeat (16) drive_cycle(1'b1, $urandom, $urandom, 1'b0, '0);
        end_test("reset default");

        drive_cycle(1'b0, '0, '0, 1'b1, make_cfg(vmul_pkg::SEW32, 1'b1));
        drive_cycle(1'b1, '1, '1, 1'b0, '0);
        drive_cycle(1'b1, '1, '0, 1'b0, '0);
        drive_cycle(1'b1, '0, '1, 1'b0, '0);
        repeat (12) drive_cycle(1'b1, $urandom, $urandom, 1'b0, '0);
        end_test("SEW32 high half");

        packed_test(vmul_pkg::SEW16, "SEW16 both halves");
        packed_test(vmul_pkg::SEW8, "SEW8 both halves");

        // Config rewrites land between back-to-back issues
        repeat (40) drive_cycle(1'b1, $urandom, $urandom, ($urandom % 3) == 0, random_cfg());
        end_test("back-to-back with config changes");

        drive_cycle(1'b0, '0, '0, 1'b1, make_cfg(vmul_pkg::SEW16, 1'b1));
        repeat (4) drive_cycle(1'b1, $urandom, $urandom, 1'b0, '0);
        drive_cycle(1'b0, '0, '0, 1'b1, bad);
        repeat (6) drive_cycle(1'b1, $urandom, $urandom, 1'b0, '0);
        drive_cycle(1'b1, $urandom, $urandom, 1'b1, bad);
        repeat (6) drive_cycle(1'b1, $urandom, $urandom, 1'b0, '0);
        end_test("unused SEW code");

        $display("Summary: %0d tests, %0d passed, %0d failed, %0d results checked, %0d errors",
                 test_num, test_num - tests_failed, tests_failed, check_count, error_count);
        if (tests_failed == 0 && error_count == 0 && !timed_out) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
src/vmul_pkg.sv
src/adder_nbit.sv
src/vedic_mul_unsigned.sv
src/vmul_cfg_regs.sv
src/vmul_lane.sv
src/vmul_top.sv
verif/vmul_chk.sv
verif/vmul_monitor.sv
verif/vmul_tb.sv

//--- run.sh
#!/bin/sh
# Build the lane testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module vmul_tb -f verilog.f -o vmul_sim

./obj_dir/vmul_sim | tee sim.log

grep -q "^TB PASSED$" sim.log
echo "Simulation passed"
